//--- test/decode_stim.txt
// I: 1 prefix opcode modrm imm pc ecx
// E: 2 alu_op op0_reg op1_reg size seg seg_valid imm opcode pc wb_valid wb_data
// alu_op 1 ADD 2 SUB 3 AND 4 OR 5 XOR 6 MOV 7 SHL 8 MOVS 9 POP a JMP; seg 0 ES 1 CS 2 SS 3 DS 4 FS 5 GS
// Simple ALU and MOV
1 00 01 d8 1234 0100 00000000
2 1 3 0 4 0 0 1234 01 0100 0 00000000
1 66 29 ca 0042 0102 00000000
2 2 1 2 2 0 0 0042 29 0102 0 00000000
1 2e 21 5e 00ff 0104 00000000
2 3 3 6 4 1 1 00ff 21 0104 0 00000000
// REP on a non-string opcode
1 f3 09 07 beef 0106 00000000
2 4 0 7 4 0 0 beef 09 0106 0 00000000
1 64 31 f1 0000 0108 00000000
2 5 6 1 4 4 1 0000 31 0108 0 00000000
1 66 8b 2c 7777 010a 00000000
2 6 5 4 2 0 0 7777 8b 010a 0 00000000
1 36 89 c3 1000 010c 00000000
2 6 0 3 4 2 1 1000 89 010c 0 00000000
// Shift by one, immediate forced to 1
1 00 d0 e0 abcd 010e 00000000
2 7 4 0 4 0 0 0001 d0 010e 0 00000000
1 65 d1 e3 0005 0110 00000000
2 7 4 3 4 5 1 0001 d1 0110 0 00000000
// Microcoded returns
1 00 c3 00 9999 0112 00000000
2 9 0 0 4 2 1 0000 c3 0112 0 00000000
2 a 0 0 4 2 1 0000 c3 0112 0 00000000
1 00 c2 00 0008 0114 00000000
2 9 0 0 4 2 1 0000 c2 0114 0 00000000
2 a 0 0 4 2 1 0008 c2 0114 0 00000000
1 00 cb 00 5555 0116 00000000
2 9 0 0 4 2 1 0000 cb 0116 0 00000000
2 9 0 0 4 2 1 0000 cb 0116 0 00000000
2 a 0 0 4 2 1 0000 cb 0116 0 00000000
1 00 ca 00 0010 0118 00000000
2 9 0 0 4 2 1 0000 ca 0118 0 00000000
2 9 0 0 4 2 1 0000 ca 0118 0 00000000
2 a 0 0 4 2 1 0010 ca 0118 0 00000000
1 66 cf 00 4321 011a 00000000
2 9 0 0 2 2 1 0000 cf 011a 0 00000000
2 9 0 0 2 2 1 0000 cf 011a 0 00000000
2 9 0 0 2 2 1 0000 cf 011a 0 00000000
2 a 0 0 2 2 1 0000 cf 011a 0 00000000
// REP MOVS with ECX 3, 1 and 0
1 f3 a5 3e 0000 011c 00000003
2 8 7 6 4 0 0 0000 a5 011c 1 00000002
2 8 7 6 4 0 0 0000 a5 011c 1 00000001
2 8 7 6 4 0 0 0000 a5 011c 1 00000000
1 f3 a5 3e 0000 011e 00000001
2 8 7 6 4 0 0 0000 a5 011e 1 00000000
1 f3 a5 3e 0000 0120 00000000
// Plain decode again after the repeats
1 3e 03 11 0abc 0122 00000000
2 1 2 1 4 3 1 0abc 03 0122 0 00000000

//--- flist.f
hdl/decode_pkg.sv
hdl/prefix_decode.sv
hdl/op_decode.sv
hdl/ucode_rom.sv
hdl/rep_counter.sv
hdl/decode_fsm.sv
hdl/decode_stage.sv
test/tb_clock.sv
test/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - hdl/decode_pkg.sv
      - hdl/prefix_decode.sv
      - hdl/op_decode.sv
      - hdl/ucode_rom.sv
      - hdl/rep_counter.sv
      - hdl/decode_fsm.sv
      - hdl/decode_stage.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_decode_stage.sv

//--- test/tb_decode_stage.sv
// ====================
// Decode stage testbench
// Stim file driven, random stage 1 back-pressure
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
   import decode_pkg::*;

   logic        ret_near;
   logic        ret_far;
   logic        s0_valid;
   s0_item_t    s0_item;
   logic        s0_ready;
   logic        s1_valid;
   logic        s1_ready;
   s1_item_t    s1_item;
   logic [31:0] ecx;
   logic        wb_valid;
   logic [31:0] wb_data;

   logic [31:0] stim_mem [0:1023];
   s0_item_t    in_item [0:63];
   logic [31:0] in_ecx [0:63];
   integer      e_end [0:63];
   s1_item_t    exp_item [0:63];
   logic        exp_wbv [0:63];
   logic [31:0] exp_wbd [0:63];

   integer n_in = 0;
   integer n_exp = 0;
   integer in_idx = 0;
   integer e_idx = 0;
   integer cycles = 0;
   integer idle_cycles = 0;
   integer cycle_limit = 0;
   integer value_errors = 0;
   integer proto_errors = 0;
   integer seed = 83;
   logic   run_done = 1'b0;
   logic   hung = 1'b0;

   tb_clock u_clk (
      .ret_near (ret_near),
      .ret_far  (ret_far)
   );

   decode_stage uut (
      .ret_near (ret_near),
      .ret_far  (ret_far),
      .s0_valid (s0_valid),
      .s0_item  (s0_item),
      .s0_ready (s0_ready),
      .s1_valid (s1_valid),
      .s1_ready (s1_ready),
      .s1_item  (s1_item),
      .ecx      (ecx),
      .wb_valid (wb_valid),
      .wb_data  (wb_data)
   );

   // Tag 1 is an instruction, tag 2 an expected item of the instruction before it
   task load_stim;
      integer p;
      begin
         $readmemh("test/decode_stim.txt", stim_mem);
         p = 0;
         while (stim_mem[p] == 32'h1 || stim_mem[p] == 32'h2) begin
            if (stim_mem[p] == 32'h1) begin
               in_item[n_in] = {stim_mem[p+1][7:0], stim_mem[p+2][7:0], stim_mem[p+3][7:0],
                                stim_mem[p+4][15:0], stim_mem[p+5][15:0]};
               in_ecx[n_in] = stim_mem[p+6];
               e_end[n_in]  = n_exp;
               n_in = n_in + 1;
               p = p + 7;
            end else begin
               exp_item[n_exp] = {stim_mem[p+1][3:0], stim_mem[p+2][2:0], stim_mem[p+3][2:0],
                                  stim_mem[p+4][2:0], stim_mem[p+5][2:0], stim_mem[p+6][0],
                                  stim_mem[p+7][15:0], stim_mem[p+8][7:0], stim_mem[p+9][15:0]};
               exp_wbv[n_exp] = stim_mem[p+10][0];
               exp_wbd[n_exp] = stim_mem[p+11];
               e_end[n_in-1]  = n_exp + 1;
               n_exp = n_exp + 1;
               p = p + 12;
            end
         end
         if (n_in == 0) begin
            proto_errors = proto_errors + 1;
            $display("No instruction records could be read from the stim file");
         end
      end
   endtask

   task report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
      begin
         value_errors = value_errors + 1;
         $display("[FAIL] %s: expected 0x%0h, actual 0x%0h (item %0d, cycle %0d)",
                  name, exp, act, e_idx, cycles);
      end
   endtask

   task check_item;
      s1_item_t exp;
      s1_item_t got;
      begin
         got = s1_item;
         if (in_idx >= n_in || e_idx >= e_end[in_idx]) begin
            proto_errors = proto_errors + 1;
            $display("Unexpected s1 item at cycle %0d with no expected record left", cycles);
         end else begin
            exp = exp_item[e_idx];
            if (got.alu_op !== exp.alu_op)
               report_mismatch("alu_op", exp.alu_op, got.alu_op);
            if (got.op0_reg !== exp.op0_reg)
               report_mismatch("op0_reg", exp.op0_reg, got.op0_reg);
            if (got.op1_reg !== exp.op1_reg)
               report_mismatch("op1_reg", exp.op1_reg, got.op1_reg);
            if (got.size !== exp.size)
               report_mismatch("size", exp.size, got.size);
            if (got.seg !== exp.seg)
               report_mismatch("seg", exp.seg, got.seg);
            if (got.seg_valid !== exp.seg_valid)
               report_mismatch("seg_valid", exp.seg_valid, got.seg_valid);
            if (got.imm !== exp.imm)
               report_mismatch("imm", exp.imm, got.imm);
            if (got.opcode !== exp.opcode)
               report_mismatch("opcode", exp.opcode, got.opcode);
            if (got.pc !== exp.pc)
               report_mismatch("pc", exp.pc, got.pc);
            if (wb_valid !== exp_wbv[e_idx])
               report_mismatch("wb_valid", exp_wbv[e_idx], wb_valid);
            if (exp_wbv[e_idx] && wb_data !== exp_wbd[e_idx])
               report_mismatch("wb_data", exp_wbd[e_idx], wb_data);
            e_idx = e_idx + 1;
         end
      end
   endtask

   // Stage 0 must take an instruction only with its last item
   task accept_input;
      begin
         if (e_idx != e_end[in_idx]) begin
            proto_errors = proto_errors + 1;
            $display("Instruction %0d accepted after item %0d, expected after item %0d",
                     in_idx, e_idx, e_end[in_idx]);
         end
         in_idx = in_idx + 1;
      end
   endtask

   task drive_inputs;
      begin
         if (in_idx < n_in) begin
            s0_valid <= 1'b1;
            s0_item  <= in_item[in_idx];
            ecx      <= in_ecx[in_idx];
         end else begin
            s0_valid <= 1'b0;
         end
         // About 70 percent ready
         s1_ready <= (({$random(seed)} % 10) < 7);
      end
   endtask

   always @(posedge ret_near) begin
      if (!ret_far && !run_done && !hung) begin
         cycles = cycles + 1;
         if (s1_valid && s1_ready) begin
            check_item();
         end else if (wb_valid) begin
            proto_errors = proto_errors + 1;
            $display("wb_valid high at cycle %0d without an s1 handshake", cycles);
         end
         if (s0_valid && s0_ready) begin
            accept_input();
         end
         if (in_idx >= n_in) begin
            idle_cycles = idle_cycles + 1;
         end
         if (cycles >= cycle_limit) begin
            hung = 1'b1;
         end else if (idle_cycles > 4) begin
            run_done = 1'b1;
         end
         drive_inputs();
      end
   end

   initial begin
      s0_valid = 1'b0;
      s0_item  = '0;
      s1_ready = 1'b0;
      ecx      = 32'd0;
      load_stim();
      cycle_limit = (n_in + n_exp) * 8 + 50;
      wait (run_done || hung);
      if (hung) begin
         proto_errors = proto_errors + 1;
         $display("Timeout after %0d cycles, the decode stage hangs", cycle_limit);
      end else if (e_idx != n_exp) begin
         proto_errors = proto_errors + 1;
         $display("Run ended with %0d of %0d expected items missing", n_exp - e_idx, n_exp);
      end
      $display("Errors: %0d value mismatches, %0d protocol errors", value_errors, proto_errors);
      if (value_errors == 0 && proto_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// ====================
// Testbench clock and reset
// 4 ns clock, reset held for 8 cycles
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic ret_near,
   output logic ret_far
);

   initial begin
      ret_near = 1'b0;
      forever #2 ret_near = ~ret_near;
   end

   initial begin
      ret_far = 1'b1;
      repeat (8) @(posedge ret_near);
      ret_far <= 1'b0;
   end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
// ====================
// Decode stage top
// Stage 0 item in, decoded stage 1 item out
// ====================
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  logic                 ret_near,
   input  logic                 ret_far,
   input  logic                 s0_valid,
   input  decode_pkg::s0_item_t s0_item,
   output logic                 s0_ready,
   output logic                 s1_valid,
   input  logic                 s1_ready,
   output decode_pkg::s1_item_t s1_item,
   input  logic [31:0]          ecx,
   output logic                 wb_valid,
   output logic [31:0]          wb_data
);
   import decode_pkg::*;

   seg_e       seg;
   logic       seg_valid;
   logic       rep;
   logic       size_ovr;
   s1_item_t   direct;
   s1_item_t   rom_uop;
   rom_entry_e rom_entry;
   logic       is_string;
   logic       rom_last;
   logic       cnt_zero;
   logic       cnt_last;
   logic       use_rom;
   logic       rom_advance;
   logic       rom_clear;
   logic       cnt_load;
   logic       cnt_dec;

   prefix_decode u_prefix (
      .prefix    (s0_item.prefix),
      .seg       (seg),
      .seg_valid (seg_valid),
      .rep       (rep),
      .size_ovr  (size_ovr)
   );

   op_decode u_op (
      .item      (s0_item),
      .size_ovr  (size_ovr),
      .seg       (seg),
      .seg_valid (seg_valid),
      .direct    (direct),
      .rom_entry (rom_entry),
      .is_string (is_string)
   );

   ucode_rom u_rom (
      .ret_near    (ret_near),
      .ret_far     (ret_far),
      .rom_entry   (rom_entry),
      .item        (s0_item),
      .size_ovr    (size_ovr),
      .rom_advance (rom_advance),
      .rom_clear   (rom_clear),
      .uop         (rom_uop),
      .last        (rom_last)
   );

   rep_counter u_cnt (
      .ret_near (ret_near),
      .ret_far  (ret_far),
      .ecx      (ecx),
      .cnt_load (cnt_load),
      .cnt_dec  (cnt_dec),
      .cnt_zero (cnt_zero),
      .cnt_last (cnt_last),
      .wb_data  (wb_data)
   );

   decode_fsm u_fsm (
      .ret_near    (ret_near),
      .ret_far     (ret_far),
      .s0_valid    (s0_valid),
      .s1_ready    (s1_ready),
      .rep         (rep),
      .is_string   (is_string),
      .rom_entry   (rom_entry),
      .rom_last    (rom_last),
      .cnt_zero    (cnt_zero),
      .cnt_last    (cnt_last),
      .s0_ready    (s0_ready),
      .s1_valid    (s1_valid),
      .use_rom     (use_rom),
      .rom_advance (rom_advance),
      .rom_clear   (rom_clear),
      .cnt_load    (cnt_load),
      .cnt_dec     (cnt_dec),
      .wb_valid    (wb_valid)
   );

   assign s1_item = use_rom ? rom_uop : direct;

endmodule

`default_nettype wire

//--- hdl/decode_fsm.sv
// ====================
// Decode control FSM
// Direct, microcode and repeat sequencing
// ====================
`timescale 1ns/1ps
`default_nettype none

module decode_fsm (
   input  logic                   ret_near,
   input  logic                   ret_far,
   input  logic                   s0_valid,
   input  logic                   s1_ready,
   input  logic                   rep,
   input  logic                   is_string,
   input  decode_pkg::rom_entry_e rom_entry,
   input  logic                   rom_last,
   input  logic                   cnt_zero,
   input  logic                   cnt_last,
   output logic                   s0_ready,
   output logic                   s1_valid,
   output logic                   use_rom,
   output logic                   rom_advance,
   output logic                   rom_clear,
   output logic                   cnt_load,
   output logic                   cnt_dec,
   output logic                   wb_valid
);
   import decode_pkg::*;

   fsm_state_e state;
   fsm_state_e state_next;
   logic       s1_hs;

   assign s1_hs = s1_valid && s1_ready;

   always_ff @(posedge ret_near or posedge ret_far) begin
      if (ret_far) begin
         state <= DIRECT;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next  = state;
      s0_ready    = s1_ready;
      s1_valid    = s0_valid;
      use_rom     = 1'b0;
      rom_advance = 1'b0;
      rom_clear   = 1'b0;
      cnt_load    = 1'b0;
      cnt_dec     = 1'b0;
      wb_valid    = 1'b0;
      case (state)
         DIRECT: begin
            if (s0_valid && rom_entry != NONE) begin
               // One bubble while the ROM takes over
               s1_valid   = 1'b0;
               s0_ready   = 1'b0;
               state_next = ROM;
            end else if (s0_valid && rep && is_string) begin
               if (cnt_zero) begin
                  s1_valid = 1'b0;
                  s0_ready = 1'b1;
               end else begin
                  s0_ready = s1_ready && cnt_last;
                  wb_valid = s1_hs;
                  cnt_load = s1_hs;
                  if (s1_hs && !cnt_last) begin
                     state_next = REPEAT;
                  end
               end
            end
         end
         ROM: begin
            use_rom     = 1'b1;
            s0_ready    = s1_ready && rom_last;
            rom_advance = s1_hs && !rom_last;
            rom_clear   = s1_hs && rom_last;
            if (s1_hs && rom_last) begin
               state_next = DIRECT;
            end
         end
         REPEAT: begin
            s0_ready = s1_ready && cnt_last;
            wb_valid = s1_hs;
            cnt_dec  = s1_hs;
            if (s1_hs && cnt_last) begin
               state_next = DIRECT;
            end
         end
         default: state_next = DIRECT;
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/rep_counter.sv
// ====================
// REP count register
// Copy of ECX counted down per iteration
// ====================
`timescale 1ns/1ps
`default_nettype none

module rep_counter (
   input  logic        ret_near,
   input  logic        ret_far,
   input  logic [31:0] ecx,
   input  logic        cnt_load,
   input  logic        cnt_dec,
   output logic        cnt_zero,
   output logic        cnt_last,
   output logic [31:0] wb_data
);

   logic [31:0] count;
   logic [31:0] cur;

   always_ff @(posedge ret_near or posedge ret_far) begin
      if (ret_far) begin
         count <= 32'd0;
      end else if (cnt_load) begin
         count <= ecx - 32'd1;
      end else if (cnt_dec) begin
         count <= count - 32'd1;
      end
   end

   // Held count is nonzero only while a repeat is in flight
   assign cur = (count != 32'd0) ? count : ecx;

   assign cnt_zero = (cur == 32'd0);
   assign cnt_last = (cur == 32'd1);
   assign wb_data  = cur - 32'd1;

endmodule

`default_nettype wire

//--- hdl/ucode_rom.sv
// ====================
// Microcode ROM
// POP/JMP sequences for the return opcodes
// ====================
`timescale 1ns/1ps
`default_nettype none

module ucode_rom (
   input  logic                   ret_near,
   input  logic                   ret_far,
   input  decode_pkg::rom_entry_e rom_entry,
   input  decode_pkg::s0_item_t   item,
   input  logic                   size_ovr,
   input  logic                   rom_advance,
   input  logic                   rom_clear,
   output decode_pkg::s1_item_t   uop,
   output logic                   last
);
   import decode_pkg::*;

   logic [1:0] step;
   alu_op_e    uop_alu;
   logic       has_imm;

   always_ff @(posedge ret_near or posedge ret_far) begin
      if (ret_far) begin
         step <= 2'd0;
      end else if (rom_clear) begin
         step <= 2'd0;
      end else if (rom_advance) begin
         step <= step + 2'd1;
      end
   end

   // Sequence table
   always_comb begin
      case ({rom_entry, step})
         {RET_NEAR, 2'd0}: {uop_alu, last} = {POP, 1'b0};
         {RET_NEAR, 2'd1}: {uop_alu, last} = {JMP, 1'b1};
         {RET_FAR, 2'd0}:  {uop_alu, last} = {POP, 1'b0};
         {RET_FAR, 2'd1}:  {uop_alu, last} = {POP, 1'b0};
         {RET_FAR, 2'd2}:  {uop_alu, last} = {JMP, 1'b1};
         {IRETD, 2'd0}:    {uop_alu, last} = {POP, 1'b0};
         {IRETD, 2'd1}:    {uop_alu, last} = {POP, 1'b0};
         {IRETD, 2'd2}:    {uop_alu, last} = {POP, 1'b0};
         {IRETD, 2'd3}:    {uop_alu, last} = {JMP, 1'b1};
         default:          {uop_alu, last} = {NOP, 1'b1};
      endcase
   end

   // C2 and CA release extra stack bytes on the jump
   assign has_imm = (item.opcode == OP_RET_NEAR_IMM) || (item.opcode == OP_RET_FAR_IMM);

   always_comb begin
      uop.alu_op    = uop_alu;
      uop.op0_reg   = TEMP_REG;
      uop.op1_reg   = TEMP_REG;
      uop.size      = size_ovr ? 3'd2 : 3'd4;
      uop.seg       = SS;
      uop.seg_valid = 1'b1;
      uop.imm       = (uop_alu == JMP && has_imm) ? item.imm : 16'd0;
      uop.opcode    = item.opcode;
      uop.pc        = item.pc;
   end

endmodule

`default_nettype wire

//--- hdl/op_decode.sv
// ====================
// Opcode and ModRM decode
// Direct item and microcode entry
// ====================
`timescale 1ns/1ps
`default_nettype none

module op_decode (
   input  decode_pkg::s0_item_t   item,
   input  logic                   size_ovr,
   input  decode_pkg::seg_e       seg,
   input  logic                   seg_valid,
   output decode_pkg::s1_item_t   direct,
   output decode_pkg::rom_entry_e rom_entry,
   output logic                   is_string
);
   import decode_pkg::*;

   alu_op_e alu_op;
   logic    force_one;

   always_comb begin
      case (item.opcode) inside
         [8'h00:8'h03]:        alu_op = ADD;
         [8'h08:8'h0B]:        alu_op = OR;
         [8'h20:8'h23]:        alu_op = AND;
         [8'h28:8'h2B]:        alu_op = SUB;
         [8'h30:8'h33]:        alu_op = XOR;
         [8'h88:8'h8B]:        alu_op = MOV;
         OP_SHL1_B, OP_SHL1_V: alu_op = SHL;
         OP_MOVS:              alu_op = MOVS;
         default:              alu_op = NOP;
      endcase
   end

   always_comb begin
      case (item.opcode)
         OP_RET_NEAR, OP_RET_NEAR_IMM: rom_entry = RET_NEAR;
         OP_RET_FAR, OP_RET_FAR_IMM:   rom_entry = RET_FAR;
         OP_IRETD:                     rom_entry = IRETD;
         default:                      rom_entry = NONE;
      endcase
   end

   // Shift by one has no immediate byte of its own
   assign force_one = (item.opcode == OP_SHL1_B) || (item.opcode == OP_SHL1_V);
   assign is_string = (item.opcode == OP_MOVS);

   always_comb begin
      direct.alu_op    = alu_op;
      direct.op0_reg   = item.modrm[5:3];
      direct.op1_reg   = item.modrm[2:0];
      direct.size      = size_ovr ? 3'd2 : 3'd4;
      direct.seg       = seg;
      direct.seg_valid = seg_valid;
      direct.imm       = force_one ? 16'd1 : item.imm;
      direct.opcode    = item.opcode;
      direct.pc        = item.pc;
   end

endmodule

`default_nettype wire

//--- hdl/prefix_decode.sv
// ====================
// Prefix decode
// Segment override, REP and operand size
// ====================
`timescale 1ns/1ps
`default_nettype none

module prefix_decode (
   input  logic [7:0]       prefix,
   output decode_pkg::seg_e seg,
   output logic             seg_valid,
   output logic             rep,
   output logic             size_ovr
);
   import decode_pkg::*;

   always_comb begin
      seg       = ES;
      seg_valid = 1'b1;
      rep       = 1'b0;
      size_ovr  = 1'b0;
      case (prefix)
         PFX_ES: seg = ES;
         PFX_CS: seg = CS;
         PFX_SS: seg = SS;
         PFX_DS: seg = DS;
         PFX_FS: seg = FS;
         PFX_GS: seg = GS;
         default: begin
            seg_valid = 1'b0;
            rep       = (prefix == PFX_REP);
            size_ovr  = (prefix == PFX_SIZE);
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/decode_pkg.sv
// ====================
// Decode stage package
// Stage items, enums and opcode constants
// ====================
`default_nettype none

package decode_pkg;

   // Prefix bytes
   localparam logic [7:0] PFX_REP  = 8'hF3;
   localparam logic [7:0] PFX_SIZE = 8'h66;
   localparam logic [7:0] PFX_ES   = 8'h26;
   localparam logic [7:0] PFX_CS   = 8'h2E;
   localparam logic [7:0] PFX_SS   = 8'h36;
   localparam logic [7:0] PFX_DS   = 8'h3E;
   localparam logic [7:0] PFX_FS   = 8'h64;
   localparam logic [7:0] PFX_GS   = 8'h65;

   // Opcodes with special handling
   localparam logic [7:0] OP_MOVS         = 8'hA5;
   localparam logic [7:0] OP_SHL1_B       = 8'hD0;
   localparam logic [7:0] OP_SHL1_V       = 8'hD1;
   localparam logic [7:0] OP_RET_NEAR     = 8'hC3;
   localparam logic [7:0] OP_RET_NEAR_IMM = 8'hC2;
   localparam logic [7:0] OP_RET_FAR      = 8'hCB;
   localparam logic [7:0] OP_RET_FAR_IMM  = 8'hCA;
   localparam logic [7:0] OP_IRETD        = 8'hCF;

   // Microcode pops land here
   localparam logic [2:0] TEMP_REG = 3'd0;

   typedef enum logic [3:0] {
      NOP, ADD, SUB, AND, OR, XOR, MOV, SHL, MOVS, POP, JMP
   } alu_op_e;

   typedef enum logic [1:0] {NONE, RET_NEAR, RET_FAR, IRETD} rom_entry_e;

   // x86 segment register encoding
   typedef enum logic [2:0] {ES, CS, SS, DS, FS, GS} seg_e;

   typedef enum logic [1:0] {DIRECT, ROM, REPEAT} fsm_state_e;

   typedef struct packed {
      logic [7:0]  prefix;
      logic [7:0]  opcode;
      logic [7:0]  modrm;
      logic [15:0] imm;
      logic [15:0] pc;
   } s0_item_t;

   typedef struct packed {
      alu_op_e     alu_op;
      logic [2:0]  op0_reg;
      logic [2:0]  op1_reg;
      logic [2:0]  size;
      seg_e        seg;
      logic        seg_valid;
      logic [15:0] imm;
      logic [7:0]  opcode;
      logic [15:0] pc;
   } s1_item_t;

endpackage

`default_nettype wire
